// File: logic/datapath_pkg.sv
package datapath_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int unsigned XLEN        = 32;
  localparam int unsigned ILEN        = 32;
  localparam int unsigned REG_IDX_LEN = 5;

  // --------------------
  // Major opcodes (RV32I subset)
  // --------------------
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // --------------------
  // FIFO payloads
  // --------------------
  // Fetched instruction and the PC it came from
  typedef struct packed {
    logic [ILEN-1:0] instr;
    logic [XLEN-1:0] pc;
  } fetch_entry_t;

  // Pending store, waiting for the data port
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
  } store_entry_t;

endpackage

// File: logic/memif_fifo.sv
`timescale 1ns/10ps

module memif_fifo #(
  parameter int unsigned DEPTH = 2,
  parameter type entry_t = logic [31:0],
  localparam int unsigned CNT_W = $clog2(DEPTH + 1)
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,
  input  logic             push_i,
  input  entry_t           data_i,
  input  logic             pop_i,
  output entry_t           data_o,
  output logic             empty_o,
  output logic             full_o,
  output logic [CNT_W-1:0] count_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  entry_t           mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push;
  logic             do_pop;

  // Wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign count_o = cnt_q;

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage #(
  parameter logic [datapath_pkg::XLEN-1:0] BOOT_PC          = '0,
  parameter int unsigned                   MEMIF_FIFO_DEPTH = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Redirect from the backend
  input  logic                          flush_i,
  input  logic [datapath_pkg::XLEN-1:0] redirect_pc_i,
  // Instruction memory
  output logic                          instr_req_o,
  input  logic                          instr_gnt_i,
  output logic [datapath_pkg::XLEN-1:0] instr_addr_o,
  input  logic                          instr_rvalid_i,
  output logic                          instr_rready_o,
  input  logic [datapath_pkg::ILEN-1:0] instr_rdata_i,
  output logic                          early_jump_mem_flush_o,
  // Issue link
  output logic                          issue_valid_o,
  input  logic                          issue_ready_i,
  output logic [datapath_pkg::ILEN-1:0] issue_instr_o,
  output logic [datapath_pkg::XLEN-1:0] issue_pc_o
);

  import datapath_pkg::*;

  localparam int unsigned CNT_W = $clog2(MEMIF_FIFO_DEPTH + 1);

  logic [XLEN-1:0]  pc_q;
  logic             started_q;
  logic [CNT_W-1:0] disc_cnt_q;
  logic             req_acc;
  logic             rsp_acc;
  logic             rsp_drop;
  logic             rsp_keep;
  logic [CNT_W-1:0] pcq_cnt;
  logic [CNT_W-1:0] fifo_cnt;
  logic [CNT_W:0]   inflight;
  logic [XLEN-1:0]  rsp_pc;
  logic             fifo_empty;
  logic             fifo_full;
  fetch_entry_t     fifo_in;
  fetch_entry_t     fifo_out;

  // --------------------
  // Request side
  // --------------------
  assign req_acc  = instr_req_o & instr_gnt_i;
  assign inflight = {1'b0, pcq_cnt} + {1'b0, fifo_cnt};

  // Room for every outstanding response, so the FIFO never overflows
  assign instr_req_o  = started_q & (inflight < (CNT_W + 1)'(MEMIF_FIFO_DEPTH));
  assign instr_addr_o = pc_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q      <= BOOT_PC;
      started_q <= 1'b0;
    end else begin
      started_q <= 1'b1;
      if (flush_i) begin
        pc_q <= redirect_pc_i;
      end else if (req_acc) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  // PCs of requests still waiting for their response
  memif_fifo #(
    .DEPTH  (MEMIF_FIFO_DEPTH),
    .entry_t(logic [XLEN-1:0])
  ) u_pc_queue (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .flush_i(1'b0),
    .push_i (req_acc),
    .data_i (pc_q),
    .pop_i  (rsp_acc),
    .data_o (rsp_pc),
    .empty_o(),
    .full_o (),
    .count_o(pcq_cnt)
  );

  // --------------------
  // Response side
  // --------------------
  assign instr_rready_o = ~fifo_full | (disc_cnt_q != '0);
  assign rsp_acc        = instr_rvalid_i & instr_rready_o;
  assign rsp_drop       = rsp_acc & (disc_cnt_q != '0);
  assign rsp_keep       = rsp_acc & (disc_cnt_q == '0);

  // Everything still in flight at a redirect belongs to the old path
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      disc_cnt_q <= '0;
    end else if (flush_i) begin
      disc_cnt_q <= pcq_cnt + CNT_W'(req_acc) - CNT_W'(rsp_acc);
    end else if (rsp_drop) begin
      disc_cnt_q <= disc_cnt_q - 1'b1;
    end
  end

  assign early_jump_mem_flush_o = rsp_drop;

  assign fifo_in = '{instr: instr_rdata_i, pc: rsp_pc};

  memif_fifo #(
    .DEPTH  (MEMIF_FIFO_DEPTH),
    .entry_t(fetch_entry_t)
  ) u_memif_fifo (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .flush_i(flush_i),
    .push_i (rsp_keep),
    .data_i (fifo_in),
    .pop_i  (issue_valid_o & issue_ready_i),
    .data_o (fifo_out),
    .empty_o(fifo_empty),
    .full_o (fifo_full),
    .count_o(fifo_cnt)
  );

  assign issue_valid_o = ~fifo_empty;
  assign issue_instr_o = fifo_out.instr;
  assign issue_pc_o    = fifo_out.pc;

endmodule

// File: logic/backend.sv
`timescale 1ns/10ps

module backend #(
  parameter int unsigned STORE_BUF_DEPTH = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Issue link and redirect
  input  logic                          fetch_valid_i,
  output logic                          fetch_ready_o,
  input  logic [datapath_pkg::ILEN-1:0] fetch_instr_i,
  input  logic [datapath_pkg::XLEN-1:0] fetch_pc_i,
  output logic                          fetch_mis_flush_o,
  output logic [datapath_pkg::XLEN-1:0] fetch_redirect_pc_o,
  // Load port
  output logic                          mem_load_valid_o,
  input  logic                          mem_load_ready_i,
  input  logic                          mem_load_valid_i,
  output logic                          mem_load_ready_o,
  output logic [datapath_pkg::XLEN-1:0] mem_load_addr_o,
  output logic [3:0]                    mem_load_be_o,
  input  logic [datapath_pkg::XLEN-1:0] mem_load_rdata_i,
  // Store port
  output logic                          mem_store_valid_o,
  input  logic                          mem_store_ready_i,
  input  logic                          mem_store_valid_i,
  output logic                          mem_store_ready_o,
  output logic [datapath_pkg::XLEN-1:0] mem_store_addr_o,
  output logic [3:0]                    mem_store_be_o,
  output logic [datapath_pkg::XLEN-1:0] mem_store_wdata_o
);

  import datapath_pkg::*;

  typedef enum logic [1:0] {LD_IDLE, LD_REQ, LD_WAIT} ld_state_t;

  localparam int unsigned PEND_W = 3;

  logic [XLEN-1:0]        rf_q [32];
  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [REG_IDX_LEN-1:0] rd;
  logic [REG_IDX_LEN-1:0] rs1;
  logic [REG_IDX_LEN-1:0] rs2;
  logic [XLEN-1:0]        rs1_val;
  logic [XLEN-1:0]        rs2_val;
  logic [XLEN-1:0]        imm_i;
  logic [XLEN-1:0]        imm_s;
  logic [XLEN-1:0]        imm_b;
  logic [XLEN-1:0]        imm_u;
  logic [XLEN-1:0]        imm_j;
  logic                   accept;
  logic                   is_load;
  logic                   is_store;
  logic                   taken;
  logic                   wr_rd;
  logic [XLEN-1:0]        alu_res;
  logic [XLEN-1:0]        target;
  logic                   wb_en;
  logic [REG_IDX_LEN-1:0] wb_rd;
  logic [XLEN-1:0]        wb_data;
  ld_state_t              ld_state_q;
  logic [XLEN-1:0]        ld_addr_q;
  logic [REG_IDX_LEN-1:0] ld_rd_q;
  logic                   ld_done;
  logic                   flush_q;
  logic [XLEN-1:0]        redirect_q;
  logic [PEND_W-1:0]      st_pend_q;
  logic                   st_issue;
  logic                   st_resp;
  logic                   sb_empty;
  logic                   sb_full;
  store_entry_t           sb_in;
  store_entry_t           sb_head;

  // --------------------
  // Decode
  // --------------------
  assign opcode = fetch_instr_i[6:0];
  assign rd     = fetch_instr_i[11:7];
  assign funct3 = fetch_instr_i[14:12];
  assign rs1    = fetch_instr_i[19:15];
  assign rs2    = fetch_instr_i[24:20];

  assign imm_i = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:20]};
  assign imm_s = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:25], fetch_instr_i[11:7]};
  assign imm_b = {{19{fetch_instr_i[31]}}, fetch_instr_i[31], fetch_instr_i[7],
                  fetch_instr_i[30:25], fetch_instr_i[11:8], 1'b0};
  assign imm_u = {fetch_instr_i[31:12], 12'b0};
  assign imm_j = {{11{fetch_instr_i[31]}}, fetch_instr_i[31], fetch_instr_i[19:12],
                  fetch_instr_i[20], fetch_instr_i[30:21], 1'b0};

  // x0 reads as zero
  assign rs1_val = (rs1 == '0) ? '0 : rf_q[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf_q[rs2];

  assign is_load  = (opcode == OPC_LOAD);
  assign is_store = (opcode == OPC_STORE);

  // Stall while a load is busy, a redirect is pending or the store buffer is full
  assign fetch_ready_o = (ld_state_q == LD_IDLE) & ~flush_q & ~(is_store & sb_full);
  assign accept        = fetch_valid_i & fetch_ready_o;

  // --------------------
  // Execute
  // --------------------
  always_comb begin
    wr_rd   = 1'b0;
    alu_res = '0;
    taken   = 1'b0;
    target  = fetch_pc_i + imm_b;
    case (opcode)
      OPC_OP_IMM: begin
        wr_rd   = 1'b1;
        alu_res = rs1_val + imm_i;
      end
      OPC_OP: begin
        wr_rd   = 1'b1;
        alu_res = rs1_val + rs2_val;
      end
      OPC_LUI: begin
        wr_rd   = 1'b1;
        alu_res = imm_u;
      end
      // funct3[0] picks BNE over BEQ
      OPC_BRANCH: taken = (rs1_val == rs2_val) ^ funct3[0];
      OPC_JAL: begin
        wr_rd   = 1'b1;
        alu_res = fetch_pc_i + 32'd4;
        taken   = 1'b1;
        target  = fetch_pc_i + imm_j;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      flush_q <= 1'b0;
    end else begin
      flush_q <= accept & taken;
    end
  end

  always_ff @(posedge clk_i) begin
    redirect_q <= target;
  end

  assign fetch_mis_flush_o   = flush_q;
  assign fetch_redirect_pc_o = redirect_q;

  // --------------------
  // Writeback
  // --------------------
  assign wb_en   = ld_done | (accept & wr_rd);
  assign wb_rd   = ld_done ? ld_rd_q : rd;
  assign wb_data = ld_done ? mem_load_rdata_i : alu_res;

  always_ff @(posedge clk_i) begin
    if (wb_en && (wb_rd != '0)) rf_q[wb_rd] <= wb_data;
  end

  // --------------------
  // Load sequencing
  // --------------------
  assign ld_done = (ld_state_q == LD_WAIT) & mem_load_valid_i & mem_load_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ld_state_q <= LD_IDLE;
    end else begin
      case (ld_state_q)
        LD_IDLE: if (accept && is_load) ld_state_q <= LD_REQ;
        LD_REQ:  if (mem_load_valid_o && mem_load_ready_i) ld_state_q <= LD_WAIT;
        LD_WAIT: if (ld_done) ld_state_q <= LD_IDLE;
        default: ld_state_q <= LD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && is_load) begin
      ld_addr_q <= rs1_val + imm_i;
      ld_rd_q   <= rd;
    end
  end

  // Earlier stores must be written before the load goes out
  assign mem_load_valid_o = (ld_state_q == LD_REQ) & sb_empty & (st_pend_q == '0);
  assign mem_load_ready_o = 1'b1;
  assign mem_load_addr_o  = ld_addr_q;
  assign mem_load_be_o    = 4'hf;

  // --------------------
  // Store buffer
  // --------------------
  assign sb_in = '{addr: rs1_val + imm_s, data: rs2_val};

  memif_fifo #(
    .DEPTH  (STORE_BUF_DEPTH),
    .entry_t(store_entry_t)
  ) u_store_buf (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .flush_i(1'b0),
    .push_i (accept & is_store),
    .data_i (sb_in),
    .pop_i  (st_issue),
    .data_o (sb_head),
    .empty_o(sb_empty),
    .full_o (sb_full),
    .count_o()
  );

  assign mem_store_valid_o = ~sb_empty;
  assign mem_store_ready_o = 1'b1;
  assign mem_store_addr_o  = sb_head.addr;
  assign mem_store_wdata_o = sb_head.data;
  assign mem_store_be_o    = 4'hf;

  assign st_issue = mem_store_valid_o & mem_store_ready_i;
  assign st_resp  = mem_store_valid_i & mem_store_ready_o;

  // Granted stores whose write has not completed yet
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      st_pend_q <= '0;
    end else begin
      case ({st_issue, st_resp})
        2'b10:   st_pend_q <= st_pend_q + 1'b1;
        2'b01:   st_pend_q <= st_pend_q - 1'b1;
        default: st_pend_q <= st_pend_q;
      endcase
    end
  end

endmodule

// File: logic/datapath.sv
`timescale 1ns/10ps

module datapath #(
  parameter logic [datapath_pkg::XLEN-1:0] BOOT_PC                = '0,
  parameter int unsigned                   FETCH_MEMIF_FIFO_DEPTH = 2,
  parameter int unsigned                   STORE_BUF_DEPTH        = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  output logic                          mem_flush_o,
  // Instruction memory
  output logic                          instr_req_o,
  input  logic                          instr_gnt_i,
  input  logic                          instr_rvalid_i,
  output logic                          instr_rready_o,
  output logic [datapath_pkg::XLEN-1:0] instr_addr_o,
  input  logic [datapath_pkg::ILEN-1:0] instr_rdata_i,
  // --------------------
  // Data memory
  // --------------------
  output logic                          data_load_req_o,
  input  logic                          data_load_gnt_i,
  input  logic                          data_load_rvalid_i,
  output logic                          data_load_rready_o,
  output logic [datapath_pkg::XLEN-1:0] data_load_addr_o,
  output logic [3:0]                    data_load_be_o,
  input  logic [datapath_pkg::XLEN-1:0] data_load_rdata_i,
  output logic                          data_store_req_o,
  input  logic                          data_store_gnt_i,
  input  logic                          data_store_rvalid_i,
  output logic                          data_store_rready_o,
  output logic [datapath_pkg::XLEN-1:0] data_store_addr_o,
  output logic [3:0]                    data_store_be_o,
  output logic [datapath_pkg::XLEN-1:0] data_store_wdata_o
);

  import datapath_pkg::*;

  // Fetch to backend
  logic            fe_be_valid;
  logic            be_fe_ready;
  logic [ILEN-1:0] fe_be_instr;
  logic [XLEN-1:0] fe_be_pc;
  logic            be_fe_mis_flush;
  logic [XLEN-1:0] be_fe_redirect_pc;
  logic            early_jump_mem_flush;

  fetch_stage #(
    .BOOT_PC         (BOOT_PC),
    .MEMIF_FIFO_DEPTH(FETCH_MEMIF_FIFO_DEPTH)
  ) u_fetch_stage (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .flush_i               (be_fe_mis_flush),
    .redirect_pc_i         (be_fe_redirect_pc),
    .instr_req_o           (instr_req_o),
    .instr_gnt_i           (instr_gnt_i),
    .instr_addr_o          (instr_addr_o),
    .instr_rvalid_i        (instr_rvalid_i),
    .instr_rready_o        (instr_rready_o),
    .instr_rdata_i         (instr_rdata_i),
    .early_jump_mem_flush_o(early_jump_mem_flush),
    .issue_valid_o         (fe_be_valid),
    .issue_ready_i         (be_fe_ready),
    .issue_instr_o         (fe_be_instr),
    .issue_pc_o            (fe_be_pc)
  );

  backend #(
    .STORE_BUF_DEPTH(STORE_BUF_DEPTH)
  ) u_backend (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .fetch_valid_i      (fe_be_valid),
    .fetch_ready_o      (be_fe_ready),
    .fetch_instr_i      (fe_be_instr),
    .fetch_pc_i         (fe_be_pc),
    .fetch_mis_flush_o  (be_fe_mis_flush),
    .fetch_redirect_pc_o(be_fe_redirect_pc),
    .mem_load_valid_o   (data_load_req_o),
    .mem_load_ready_i   (data_load_gnt_i),
    .mem_load_valid_i   (data_load_rvalid_i),
    .mem_load_ready_o   (data_load_rready_o),
    .mem_load_addr_o    (data_load_addr_o),
    .mem_load_be_o      (data_load_be_o),
    .mem_load_rdata_i   (data_load_rdata_i),
    .mem_store_valid_o  (data_store_req_o),
    .mem_store_ready_i  (data_store_gnt_i),
    .mem_store_valid_i  (data_store_rvalid_i),
    .mem_store_ready_o  (data_store_rready_o),
    .mem_store_addr_o   (data_store_addr_o),
    .mem_store_be_o     (data_store_be_o),
    .mem_store_wdata_o  (data_store_wdata_o)
  );

  // Taken redirect or discarded fetch responses
  assign mem_flush_o = be_fe_mis_flush | early_jump_mem_flush;

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release on a falling edge, like every other input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: tb/tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model #(
  parameter int unsigned WORDS = 256,
  parameter int          SEED  = 48
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  // Instruction port
  input  logic        instr_req_i,
  input  logic [31:0] instr_addr_i,
  input  logic        instr_rready_i,
  output logic        instr_gnt_o,
  output logic        instr_rvalid_o,
  output logic [31:0] instr_rdata_o,
  // Load port
  input  logic        load_req_i,
  input  logic [31:0] load_addr_i,
  input  logic        load_rready_i,
  output logic        load_gnt_o,
  output logic        load_rvalid_o,
  output logic [31:0] load_rdata_o,
  // Store port
  input  logic        store_req_i,
  input  logic [31:0] store_addr_i,
  input  logic [31:0] store_wdata_i,
  input  logic        store_rready_i,
  output logic        store_gnt_o,
  output logic        store_rvalid_o
);

  logic [31:0] imem [WORDS];
  logic [31:0] dmem [WORDS];
  integer      seed;
  int unsigned cyc;
  // Responses in request order, each with the cycle it becomes visible
  int unsigned instr_due_q[$];
  logic [31:0] instr_dat_q[$];
  int unsigned load_due_q[$];
  logic [31:0] load_dat_q[$];
  int unsigned store_due_q[$];

  // Unused code words are ADDI x0, x0, index and data words carry their address
  task automatic fill_memories();
    for (int i = 0; i < int'(WORDS); i++) begin
      imem[i] = {i[11:0], 20'h00013};
      dmem[i] = 32'h5a000000 | 32'(i << 2);
    end
  endtask

  // High about 3 cycles in 4
  function automatic logic grant_roll();
    return ($random(seed) & 3) != 0;
  endfunction

  // One to three cycles after the grant
  function automatic int unsigned pick_latency();
    return ($unsigned($random(seed)) % 3) + 1;
  endfunction

  initial begin
    seed           = SEED;
    cyc            = 0;
    instr_gnt_o    = 1'b0;
    instr_rvalid_o = 1'b0;
    instr_rdata_o  = '0;
    load_gnt_o     = 1'b0;
    load_rvalid_o  = 1'b0;
    load_rdata_o   = '0;
    store_gnt_o    = 1'b0;
    store_rvalid_o = 1'b0;
  end

  // --------------------
  // Accept side
  // --------------------
  always @(posedge clk_i) begin
    cyc = cyc + 1;
    if (instr_rvalid_o && instr_rready_i) begin
      void'(instr_due_q.pop_front());
      void'(instr_dat_q.pop_front());
    end
    if (instr_req_i && instr_gnt_o) begin
      instr_due_q.push_back(cyc + pick_latency() - 1);
      instr_dat_q.push_back(imem[instr_addr_i[9:2]]);
    end
    if (load_rvalid_o && load_rready_i) begin
      void'(load_due_q.pop_front());
      void'(load_dat_q.pop_front());
    end
    if (load_req_i && load_gnt_o) begin
      load_due_q.push_back(cyc + pick_latency() - 1);
      load_dat_q.push_back(dmem[load_addr_i[9:2]]);
    end
    if (store_rvalid_o && store_rready_i) begin
      void'(store_due_q.pop_front());
    end
    // Write lands at the grant
    if (store_req_i && store_gnt_o) begin
      dmem[store_addr_i[9:2]] = store_wdata_i;
      store_due_q.push_back(cyc + pick_latency() - 1);
    end
  end

  // --------------------
  // Drive side
  // --------------------
  // No grants while the core is held in reset
  always @(negedge clk_i) begin
    instr_gnt_o    <= rst_n_i & grant_roll();
    load_gnt_o     <= rst_n_i & grant_roll();
    store_gnt_o    <= rst_n_i & grant_roll();
    instr_rvalid_o <= 1'b0;
    load_rvalid_o  <= 1'b0;
    store_rvalid_o <= 1'b0;
    if (instr_due_q.size() > 0 && instr_due_q[0] <= cyc) begin
      instr_rvalid_o <= 1'b1;
      instr_rdata_o  <= instr_dat_q[0];
    end
    if (load_due_q.size() > 0 && load_due_q[0] <= cyc) begin
      load_rvalid_o <= 1'b1;
      load_rdata_o  <= load_dat_q[0];
    end
    if (store_due_q.size() > 0 && store_due_q[0] <= cyc) begin
      store_rvalid_o <= 1'b1;
    end
  end

endmodule

// File: tb/tb_datapath.sv
`timescale 1ns/10ps

module tb_datapath #(
  parameter int SEED = 48
);

  import datapath_pkg::*;

  localparam logic [XLEN-1:0] BOOT_PC     = '0;
  localparam int unsigned     PROG_WORDS  = 19;
  localparam int unsigned     N_STORES    = 5;
  localparam int unsigned     N_REDIRECTS = 3;
  localparam int unsigned     MAX_CYCLES  = 40 * PROG_WORDS + 200;

  logic            clk;
  logic            rst_n;
  logic            mem_flush;
  logic            instr_req;
  logic            instr_gnt;
  logic            instr_rvalid;
  logic            instr_rready;
  logic [XLEN-1:0] instr_addr;
  logic [ILEN-1:0] instr_rdata;
  logic            load_req;
  logic            load_gnt;
  logic            load_rvalid;
  logic            load_rready;
  logic [XLEN-1:0] load_addr;
  logic [3:0]      load_be;
  logic [XLEN-1:0] load_rdata;
  logic            store_req;
  logic            store_gnt;
  logic            store_rvalid;
  logic            store_rready;
  logic [XLEN-1:0] store_addr;
  logic [3:0]      store_be;
  logic [XLEN-1:0] store_wdata;

  logic [31:0]     prog [PROG_WORDS];
  logic [31:0]     st_addr_tbl [N_STORES];
  logic [31:0]     st_data_tbl [N_STORES];
  int unsigned     st_flush_tbl [N_STORES];
  logic [31:0]     redirect_tbl [N_REDIRECTS];
  logic [31:0]     exp_fetch_pc;
  int unsigned     redirect_idx;
  int unsigned     flush_cnt;
  int unsigned     cycle_cnt;

  tb_clock_gen u_clk_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  tb_mem_model #(
    .SEED(SEED)
  ) u_mem (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .instr_req_i   (instr_req),
    .instr_addr_i  (instr_addr),
    .instr_rready_i(instr_rready),
    .instr_gnt_o   (instr_gnt),
    .instr_rvalid_o(instr_rvalid),
    .instr_rdata_o (instr_rdata),
    .load_req_i    (load_req),
    .load_addr_i   (load_addr),
    .load_rready_i (load_rready),
    .load_gnt_o    (load_gnt),
    .load_rvalid_o (load_rvalid),
    .load_rdata_o  (load_rdata),
    .store_req_i   (store_req),
    .store_addr_i  (store_addr),
    .store_wdata_i (store_wdata),
    .store_rready_i(store_rready),
    .store_gnt_o   (store_gnt),
    .store_rvalid_o(store_rvalid)
  );

  datapath #(
    .BOOT_PC(BOOT_PC)
  ) dut0 (
    .clk_i              (clk),
    .rst_n_i            (rst_n),
    .mem_flush_o        (mem_flush),
    .instr_req_o        (instr_req),
    .instr_gnt_i        (instr_gnt),
    .instr_rvalid_i     (instr_rvalid),
    .instr_rready_o     (instr_rready),
    .instr_addr_o       (instr_addr),
    .instr_rdata_i      (instr_rdata),
    .data_load_req_o    (load_req),
    .data_load_gnt_i    (load_gnt),
    .data_load_rvalid_i (load_rvalid),
    .data_load_rready_o (load_rready),
    .data_load_addr_o   (load_addr),
    .data_load_be_o     (load_be),
    .data_load_rdata_i  (load_rdata),
    .data_store_req_o   (store_req),
    .data_store_gnt_i   (store_gnt),
    .data_store_rvalid_i(store_rvalid),
    .data_store_rready_o(store_rready),
    .data_store_addr_o  (store_addr),
    .data_store_be_o    (store_be),
    .data_store_wdata_o (store_wdata)
  );

  // --------------------
  // RV32I encoders
  // --------------------
  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] r_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {7'b0, rs2, rs1, 3'b000, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic wait_store_grant();
    do begin
      @(posedge clk);
    end while (!(store_req && store_gnt));
  endtask

  // --------------------
  // Fetch address and flush monitor
  // --------------------
  always @(posedge clk) begin
    if (rst_n) begin
      if (instr_req && instr_gnt) begin
        check_value("instr_addr_o", instr_addr, exp_fetch_pc);
        exp_fetch_pc = exp_fetch_pc + 32'd4;
      end
      // Word accesses only
      if (load_req && load_gnt) begin
        check_value("data_load_be_o", {28'h0, load_be}, 32'hf);
      end
      // A request in the redirect cycle still used the old PC
      if (dut0.be_fe_mis_flush) begin
        check_value("mem_flush_o", {31'h0, mem_flush}, 32'h1);
        flush_cnt    = flush_cnt + 1;
        exp_fetch_pc = redirect_tbl[redirect_idx];
        if (redirect_idx < N_REDIRECTS - 1) begin
          redirect_idx = redirect_idx + 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the store sequence did not complete within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  initial begin
    // x2 holds the data base 0x100
    prog[0]  = i_type(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM);
    prog[1]  = i_type(12'h100, 5'd0, 3'b000, 5'd2, OPC_OP_IMM);
    prog[2]  = r_type(5'd1, 5'd1, 5'd3, OPC_OP);
    prog[3]  = u_type(20'h12345, 5'd4);
    prog[4]  = s_type(12'd0, 5'd3, 5'd2);
    prog[5]  = s_type(12'd4, 5'd4, 5'd2);
    prog[6]  = i_type(12'd0, 5'd2, 3'b010, 5'd5, OPC_LOAD);
    prog[7]  = i_type(12'd1, 5'd5, 3'b000, 5'd6, OPC_OP_IMM);
    prog[8]  = s_type(12'd8, 5'd6, 5'd2);
    // BEQ x1, x1 always taken, over two stores
    prog[9]  = b_type(13'd12, 5'd1, 5'd1, 3'b000);
    prog[10] = s_type(12'd12, 5'd1, 5'd2);
    prog[11] = s_type(12'd16, 5'd1, 5'd2);
    // BNE x1, x1 never taken
    prog[12] = b_type(13'd8, 5'd1, 5'd1, 3'b001);
    prog[13] = s_type(12'd20, 5'd1, 5'd2);
    prog[14] = j_type(21'd12, 5'd7);
    prog[15] = s_type(12'd24, 5'd1, 5'd2);
    prog[16] = s_type(12'd28, 5'd1, 5'd2);
    prog[17] = s_type(12'd32, 5'd7, 5'd2);
    // Halt by jumping to itself
    prog[18] = j_type(21'd0, 5'd0);

    // Address, data, taken redirects that must precede the store
    st_addr_tbl[0] = 32'h100;
    st_data_tbl[0] = 32'd10;
    st_flush_tbl[0] = 0;
    st_addr_tbl[1] = 32'h104;
    st_data_tbl[1] = 32'h12345000;
    st_flush_tbl[1] = 0;
    // Loaded 10 plus one
    st_addr_tbl[2] = 32'h108;
    st_data_tbl[2] = 32'd11;
    st_flush_tbl[2] = 0;
    st_addr_tbl[3] = 32'h114;
    st_data_tbl[3] = 32'd5;
    st_flush_tbl[3] = 1;
    // Link value of the JAL at 0x38
    st_addr_tbl[4] = 32'h120;
    st_data_tbl[4] = 32'h3c;
    st_flush_tbl[4] = 2;

    redirect_tbl[0] = 32'h30;
    redirect_tbl[1] = 32'h44;
    redirect_tbl[2] = 32'h48;

    exp_fetch_pc = BOOT_PC;
    redirect_idx = 0;
    flush_cnt    = 0;
    cycle_cnt    = 0;

    u_mem.fill_memories();
    for (int i = 0; i < int'(PROG_WORDS); i++) begin
      u_mem.imem[i] = prog[i];
    end

    @(posedge rst_n);
    for (int i = 0; i < int'(N_STORES); i++) begin
      wait_store_grant();
      check_value("data_store_addr_o", store_addr, st_addr_tbl[i]);
      check_value("data_store_wdata_o", store_wdata, st_data_tbl[i]);
      check_value("data_store_be_o", {28'h0, store_be}, 32'hf);
      check_value("mem_flush_o", 32'(flush_cnt >= st_flush_tbl[i]), 32'h1);
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: list.f
logic/datapath_pkg.sv
logic/memif_fifo.sv
logic/fetch_stage.sv
logic/backend.sv
logic/datapath.sv
tb/tb_clock_gen.sv
tb/tb_mem_model.sv
tb/tb_datapath.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_datapath
LOG       ?= sim.log
SEED      ?= 48
BUILD     ?= obj_dir
FLIST     ?= list.f
PASS_MSG  := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -Wno-fatal -f $(FLIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(BUILD) -o V$(TOP)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
